//--- common/burst_req_if.sv
// burst request from one path to the command sequencer; addr and beats hold from req to cmd_done
interface burst_req_if;

    // raised by the path, held until cmd_done
    logic                    req;
    ddr_bridge_pkg::addr_t   addr;
    ddr_bridge_pkg::beats_t  beats;

    // grant high through the cmd_done pulse
    logic                    grant;
    // one cycle after the last app command is accepted
    logic                    cmd_done;

    modport path (
        output req,
        output addr,
        output beats,
        input  grant,
        input  cmd_done
    );

    modport sequencer (
        input  req,
        input  addr,
        input  beats,
        output grant,
        output cmd_done
    );

endinterface

//--- common/ddr_bridge_pkg.sv
// widths and types of the bridge; FIFO_DEPTH must be a power of two and hold one whole burst
package ddr_bridge_pkg;

    // controller address and data beat
    localparam int ADDR_W = 27;
    localparam int DATA_W = 64;

    // longest AXI burst in beats
    localparam int MAX_BEATS = 16;

    // one whole burst fits in each FIFO
    localparam int FIFO_DEPTH = 16;

    // controller units per beat
    localparam int APP_ADDR_STEP = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // 1 .. MAX_BEATS, so one extra bit
    typedef logic [$clog2(MAX_BEATS+1)-1:0] beats_t;

    // AXI len field, beats minus one
    typedef logic [7:0] axi_len_t;

    // controller app_cmd codes
    typedef enum logic [2:0] {
        APP_WRITE = 3'd0,
        APP_READ  = 3'd1
    } app_cmd_e;

endpackage

//--- read_path/axi_read_path.sv
// one read burst at a time; controller returns data in command order, rresp always OKAY
module axi_read_path (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     arvalid,
    output logic                     arready,
    input  ddr_bridge_pkg::addr_t    araddr,
    input  ddr_bridge_pkg::axi_len_t arlen,
    output logic                     rvalid,
    input  logic                     rready,
    output ddr_bridge_pkg::data_t    rdata,
    output logic                     rlast,
    input  ddr_bridge_pkg::data_t    app_rd_data,
    input  logic                     app_rd_data_valid,
    burst_req_if.path                seq
);

    logic                   busy;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   fifo_full;
    logic                   fifo_empty;
    // beats already handed to the master
    ddr_bridge_pkg::beats_t r_cnt;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // anything buffered goes straight out
    assign rvalid = !fifo_empty;
    assign rlast  = rvalid && (r_cnt == seq.beats - 1'b1);

    // burst descriptor for the sequencer
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            seq.addr  <= araddr;
            seq.beats <= ddr_bridge_pkg::beats_t'(arlen) + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            arready <= 1'b0;
            seq.req <= 1'b0;
            r_cnt   <= '0;
        end else begin
            if (!busy) begin
                // first idle cycle after reset raises arready
                arready <= !ar_hs;
                if (ar_hs) begin
                    busy    <= 1'b1;
                    seq.req <= 1'b1;
                    r_cnt   <= '0;
                end
            end else begin
                if (seq.cmd_done) begin
                    seq.req <= 1'b0;
                end
                if (r_hs) begin
                    r_cnt <= r_cnt + 1'b1;
                end
                // burst ends with the rlast handshake
                if (r_hs && rlast) begin
                    busy    <= 1'b0;
                    arready <= 1'b1;
                end
            end
        end
    end

    // returned data kept in arrival order
    sync_fifo #(
        .payload_t(ddr_bridge_pkg::data_t)
    ) rd_fifo_i (
        .clock(clock),
        .rst  (rst),
        .push (app_rd_data_valid),
        .din  (app_rd_data),
        .pop  (r_hs),
        .dout (rdata),
        .full (fifo_full),
        .empty(fifo_empty)
    );

    // controller cannot be stalled, so one burst must always fit
    a_rd_room: assert property (@(posedge clock) disable iff (rst)
        app_rd_data_valid |-> !fifo_full);

endmodule

//--- src.f
common/ddr_bridge_pkg.sv
common/burst_req_if.sv
src/sync_fifo.sv
write_path/axi_write_path.sv
read_path/axi_read_path.sv
src/app_cmd_sequencer.sv
src/ddr_axi_bridge.sv
tests/ddr_app_model.sv
tests/tb_ddr_bridge.sv

//--- src/app_cmd_sequencer.sv
// one burst in flight on the app port; nothing is granted before init_calib_complete
module app_cmd_sequencer (
    input  logic                     clock,
    input  logic                     rst,
    burst_req_if.sequencer           wr,
    burst_req_if.sequencer           rd,
    output ddr_bridge_pkg::addr_t    app_addr,
    output ddr_bridge_pkg::app_cmd_e app_cmd,
    output logic                     app_en,
    input  logic                     app_rdy,
    input  logic                     init_calib_complete
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_ISSUE,
        S_DONE
    } state_e;

    state_e                 state;
    // owner of the current burst, also the round-robin pointer
    logic                   owner_rd;
    logic                   pick_rd;
    logic                   accept;
    ddr_bridge_pkg::beats_t remaining;

    // read wins if alone or if write went last
    assign pick_rd = rd.req && (!wr.req || !owner_rd);
    assign accept  = app_en && app_rdy;

    assign wr.grant    = (state != S_IDLE) && !owner_rd;
    assign rd.grant    = (state != S_IDLE) && owner_rd;
    assign wr.cmd_done = (state == S_DONE) && !owner_rd;
    assign rd.cmd_done = (state == S_DONE) && owner_rd;

    assign app_en  = (state == S_ISSUE);
    assign app_cmd = owner_rd ? ddr_bridge_pkg::APP_READ : ddr_bridge_pkg::APP_WRITE;

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            owner_rd  <= 1'b1;
            remaining <= '0;
            app_addr  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (init_calib_complete && (wr.req || rd.req)) begin
                        owner_rd <= pick_rd;
                        state    <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    // grant is up, take the owner's descriptor
                    app_addr  <= owner_rd ? rd.addr : wr.addr;
                    remaining <= owner_rd ? rd.beats : wr.beats;
                    state     <= S_ISSUE;
                end
                S_ISSUE: begin
                    if (accept) begin
                        app_addr  <= app_addr + ddr_bridge_pkg::addr_t'(
                                     ddr_bridge_pkg::APP_ADDR_STEP);
                        remaining <= remaining - 1'b1;
                        if (remaining == ddr_bridge_pkg::beats_t'(1)) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: begin
                    // cmd_done pulse, then free
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // command held intact while the controller stalls
    a_cmd_hold: assert property (@(posedge clock) disable iff (rst)
        app_en && !app_rdy |=> app_en && $stable(app_addr) && $stable(app_cmd));

endmodule

//--- src/ddr_axi_bridge.sv
// AXI4 INCR bursts of 1 to 16 beats to the DDR app port, no IDs, byte mask and wdf_end left to the user
module ddr_axi_bridge (
    input  logic                     clock,
    input  logic                     rst,
    // AXI write address, data, response
    input  logic                     awvalid,
    output logic                     awready,
    input  ddr_bridge_pkg::addr_t    awaddr,
    input  ddr_bridge_pkg::axi_len_t awlen,
    input  logic                     wvalid,
    output logic                     wready,
    input  ddr_bridge_pkg::data_t    wdata,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    // AXI read address and data
    input  logic                     arvalid,
    output logic                     arready,
    input  ddr_bridge_pkg::addr_t    araddr,
    input  ddr_bridge_pkg::axi_len_t arlen,
    output logic                     rvalid,
    input  logic                     rready,
    output ddr_bridge_pkg::data_t    rdata,
    output logic                     rlast,
    // controller app port
    output ddr_bridge_pkg::addr_t    app_addr,
    output ddr_bridge_pkg::app_cmd_e app_cmd,
    output logic                     app_en,
    input  logic                     app_rdy,
    output ddr_bridge_pkg::data_t    app_wdf_data,
    output logic                     app_wdf_wren,
    input  logic                     app_wdf_rdy,
    input  ddr_bridge_pkg::data_t    app_rd_data,
    input  logic                     app_rd_data_valid,
    input  logic                     init_calib_complete
);

    // one request channel per path
    burst_req_if wr_req ();
    burst_req_if rd_req ();

    axi_write_path axi_write_path_i (
        .clock       (clock),
        .rst         (rst),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wlast       (wlast),
        .bvalid      (bvalid),
        .bready      (bready),
        .app_wdf_data(app_wdf_data),
        .app_wdf_wren(app_wdf_wren),
        .app_wdf_rdy (app_wdf_rdy),
        .seq         (wr_req.path)
    );

    axi_read_path axi_read_path_i (
        .clock            (clock),
        .rst              (rst),
        .arvalid          (arvalid),
        .arready          (arready),
        .araddr           (araddr),
        .arlen            (arlen),
        .rvalid           (rvalid),
        .rready           (rready),
        .rdata            (rdata),
        .rlast            (rlast),
        .app_rd_data      (app_rd_data),
        .app_rd_data_valid(app_rd_data_valid),
        .seq              (rd_req.path)
    );

    // arbitration and the shared command bus
    app_cmd_sequencer app_cmd_sequencer_i (
        .clock              (clock),
        .rst                (rst),
        .wr                 (wr_req.sequencer),
        .rd                 (rd_req.sequencer),
        .app_addr           (app_addr),
        .app_cmd            (app_cmd),
        .app_en             (app_en),
        .app_rdy            (app_rdy),
        .init_calib_complete(init_calib_complete)
    );

endmodule

//--- src/sync_fifo.sv
// show-ahead single-clock FIFO; depth from the package must be a power of two, no overflow guard
module sync_fifo #(
    parameter type payload_t = ddr_bridge_pkg::data_t
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = $clog2(ddr_bridge_pkg::FIFO_DEPTH);
    localparam int CNT_W = $clog2(ddr_bridge_pkg::FIFO_DEPTH + 1);

    payload_t             mem [ddr_bridge_pkg::FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    // storage, no reset
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap naturally
    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // head entry always visible
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(ddr_bridge_pkg::FIFO_DEPTH));

    // the users must respect full and empty
    a_no_overrun: assert property (@(posedge clock) disable iff (rst)
        !(push && full) && !(pop && empty));

endmodule

//--- tests/ddr_app_model.sv
// app port model: reads return in order after READ_LATENCY cycles; memory decodes address bits 12:3 only
module ddr_app_model (
    input  logic                     clock,
    input  logic                     rst,
    input  ddr_bridge_pkg::addr_t    app_addr,
    input  ddr_bridge_pkg::app_cmd_e app_cmd,
    input  logic                     app_en,
    output logic                     app_rdy,
    input  ddr_bridge_pkg::data_t    app_wdf_data,
    input  logic                     app_wdf_wren,
    output logic                     app_wdf_rdy,
    output ddr_bridge_pkg::data_t    app_rd_data,
    output logic                     app_rd_data_valid,
    output logic                     init_calib_complete,
    input  logic                     cmd_stall,
    input  logic                     wdf_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CALIB_CYCLES = 20;
    localparam int READ_LATENCY = 3;

    ddr_bridge_pkg::data_t mem [1024];
    logic                  mem_valid [1024];

    // accepted but not yet paired
    ddr_bridge_pkg::addr_t wr_addr_q [$];
    ddr_bridge_pkg::data_t wdf_q [$];
    // pending reads and the cycle each is due
    ddr_bridge_pkg::addr_t rd_addr_q [$];
    int                    rd_due_q [$];

    int                    cycle;
    int                    calib_cnt;
    ddr_bridge_pkg::addr_t wa;
    ddr_bridge_pkg::addr_t ra;

    logic                  calib_q = 1'b0;
    logic                  rd_valid_q = 1'b0;
    ddr_bridge_pkg::data_t rd_data_q = '0;

    assign init_calib_complete = calib_q;
    assign app_rdy             = calib_q && !cmd_stall;
    assign app_wdf_rdy         = calib_q && !wdf_stall;
    assign app_rd_data_valid   = rd_valid_q;
    assign app_rd_data         = rd_data_q;

    // never-written words carry their full address
    function automatic ddr_bridge_pkg::data_t fill_word(input ddr_bridge_pkg::addr_t a);
        return 64'hf111_0000_0000_0000 | 64'(a);
    endfunction

    function automatic ddr_bridge_pkg::data_t read_word(input ddr_bridge_pkg::addr_t a);
        if (mem_valid[a[12:3]]) begin
            return mem[a[12:3]];
        end
        return fill_word(a);
    endfunction

    always @(posedge clock or posedge rst) begin
        if (rst) begin
            cycle = 0;
            calib_cnt = 0;
            calib_q <= 1'b0;
            rd_valid_q <= 1'b0;
            wr_addr_q.delete();
            wdf_q.delete();
            rd_addr_q.delete();
            rd_due_q.delete();
            foreach (mem_valid[i]) begin
                mem_valid[i] = 1'b0;
            end
        end else begin
            cycle = cycle + 1;
            // calibration finishes a while after reset
            if (calib_cnt < CALIB_CYCLES) begin
                calib_cnt = calib_cnt + 1;
            end else begin
                calib_q <= 1'b1;
            end
            if (app_en && app_rdy) begin
                if (app_cmd == ddr_bridge_pkg::APP_WRITE) begin
                    wr_addr_q.push_back(app_addr);
                end else begin
                    rd_addr_q.push_back(app_addr);
                    rd_due_q.push_back(cycle + READ_LATENCY);
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wdf_q.push_back(app_wdf_data);
            end
            // each write command takes the next data beat
            while (wr_addr_q.size() > 0 && wdf_q.size() > 0) begin
                wa = wr_addr_q.pop_front();
                mem[wa[12:3]] = wdf_q.pop_front();
                mem_valid[wa[12:3]] = 1'b1;
            end
            // at most one read beat per cycle
            if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
                ra = rd_addr_q.pop_front();
                void'(rd_due_q.pop_front());
                rd_data_q <= read_word(ra);
                rd_valid_q <= 1'b1;
            end else begin
                rd_valid_q <= 1'b0;
            end
        end
    end

endmodule

//--- tests/ddr_bridge_input.txt
# dir (W write, R read), start address hex, beats decimal, base data hex
# write beat k carries base+k; base is unused on reads
W 0000100 4 1111000000000000
R 0000100 4 0
W 0000200 1 2222000000000000
R 0000200 1 0
W 0000400 16 3333000000000000
R 0000400 16 0
W 0000120 2 4444000000000000
R 0000100 8 0
R 0000800 3 0
W 0000400 16 5555000000000000
R 0000400 16 0
W 0001f80 16 6666000000000000
R 0001f80 16 0

//--- tests/tb_ddr_bridge.sv
// runs the bursts of tests/ddr_bridge_input.txt one after another; addresses 8-aligned, below 0x2000
module tb_ddr_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;

    logic                     clock = 1'b0;
    logic                     rst;
    logic                     awvalid;
    logic                     awready;
    ddr_bridge_pkg::addr_t    awaddr;
    ddr_bridge_pkg::axi_len_t awlen;
    logic                     wvalid;
    logic                     wready;
    ddr_bridge_pkg::data_t    wdata;
    logic                     wlast;
    logic                     bvalid;
    logic                     bready = 1'b0;
    logic                     arvalid;
    logic                     arready;
    ddr_bridge_pkg::addr_t    araddr;
    ddr_bridge_pkg::axi_len_t arlen;
    logic                     rvalid;
    logic                     rready = 1'b0;
    ddr_bridge_pkg::data_t    rdata;
    logic                     rlast;
    ddr_bridge_pkg::addr_t    app_addr;
    ddr_bridge_pkg::app_cmd_e app_cmd;
    logic                     app_en;
    logic                     app_rdy;
    ddr_bridge_pkg::data_t    app_wdf_data;
    logic                     app_wdf_wren;
    logic                     app_wdf_rdy;
    ddr_bridge_pkg::data_t    app_rd_data;
    logic                     app_rd_data_valid;
    logic                     init_calib_complete;
    logic                     cmd_stall = 1'b0;
    logic                     wdf_stall = 1'b0;

    logic [31:0]              rnd_state = 32'd15383;

    // expected memory contents, same decode as the controller
    ddr_bridge_pkg::data_t    exp_mem [1024];
    logic                     exp_valid [1024];

    // expected app commands and r beats in order
    ddr_bridge_pkg::addr_t    exp_cmd_addr [$];
    ddr_bridge_pkg::app_cmd_e exp_cmd_code [$];
    ddr_bridge_pkg::data_t    exp_rd_data [$];
    logic                     exp_rd_last [$];

    int                       value_errors = 0;
    int                       other_errors = 0;
    int                       b_count = 0;
    int                       n_writes = 0;
    logic                     hung = 1'b0;
    logic                     w_done = 1'b0;
    logic                     prev_b_stall = 1'b0;

    ddr_axi_bridge ddr_axi_bridge_i (.*);

    ddr_app_model app_model_i (
        .clock              (clock),
        .rst                (rst),
        .app_addr           (app_addr),
        .app_cmd            (app_cmd),
        .app_en             (app_en),
        .app_rdy            (app_rdy),
        .app_wdf_data       (app_wdf_data),
        .app_wdf_wren       (app_wdf_wren),
        .app_wdf_rdy        (app_wdf_rdy),
        .app_rd_data        (app_rd_data),
        .app_rd_data_valid  (app_rd_data_valid),
        .init_calib_complete(init_calib_complete),
        .cmd_stall          (cmd_stall),
        .wdf_stall          (wdf_stall)
    );

    initial begin
        forever begin
            #50 clock = ~clock;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ready stalls, each ready high about three cycles in four
    always @(posedge clock) begin
        rnd_state = xorshift(rnd_state);
        bready    <= (rnd_state[1:0] != 2'd0);
        rready    <= (rnd_state[3:2] != 2'd0);
        cmd_stall <= (rnd_state[5:4] == 2'd0);
        wdf_stall <= (rnd_state[7:6] == 2'd0);
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        other_errors++;
        hung = 1'b1;
    endtask

    // unwritten words read back with their address in the low bits
    function automatic ddr_bridge_pkg::data_t expected_word(input ddr_bridge_pkg::addr_t a);
        if (exp_valid[a[12:3]]) begin
            return exp_mem[a[12:3]];
        end
        return 64'hf111_0000_0000_0000 | 64'(a);
    endfunction

    // all outputs are steady at the falling edge
    always @(negedge clock) begin
        if (!rst) begin
            if (app_en && app_rdy) begin
                if (exp_cmd_addr.size() == 0) begin
                    $display("app command at %0t with none expected", $time);
                    other_errors++;
                end else begin
                    check_value("app_addr", app_addr, exp_cmd_addr.pop_front());
                    check_value("app_cmd", app_cmd, exp_cmd_code.pop_front());
                end
            end
            if (rvalid && rready) begin
                if (exp_rd_data.size() == 0) begin
                    $display("r beat at %0t with none expected", $time);
                    other_errors++;
                end else begin
                    check_value("rdata", rdata, exp_rd_data.pop_front());
                    check_value("rlast", rlast, exp_rd_last.pop_front());
                end
            end
            if (bvalid && bready) begin
                b_count++;
            end
            // bvalid held through a stall, never ahead of wlast
            if (prev_b_stall) begin
                check_value("bvalid", bvalid, 1'b1);
            end
            if (bvalid && !w_done) begin
                check_value("bvalid", bvalid, 1'b0);
            end
            prev_b_stall = bvalid && !bready;
        end
    end

    task automatic run_write(input ddr_bridge_pkg::addr_t addr, input int beats,
                             input ddr_bridge_pkg::data_t base);
        int k;
        int cycles;
        ddr_bridge_pkg::addr_t a;
        for (k = 0; k < beats; k++) begin
            a = ddr_bridge_pkg::addr_t'(addr + ddr_bridge_pkg::APP_ADDR_STEP * k);
            exp_cmd_addr.push_back(a);
            exp_cmd_code.push_back(ddr_bridge_pkg::APP_WRITE);
            exp_mem[a[12:3]] = base + k;
            exp_valid[a[12:3]] = 1'b1;
        end
        w_done = 1'b0;
        @(posedge clock);
        awvalid <= 1'b1;
        awaddr  <= addr;
        awlen   <= ddr_bridge_pkg::axi_len_t'(beats - 1);
        cycles = 0;
        @(negedge clock);
        while (!awready && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!awready) begin
            report_timeout("awready");
            return;
        end
        @(posedge clock);
        awvalid <= 1'b0;
        for (k = 0; k < beats; k++) begin
            wvalid <= 1'b1;
            wdata  <= base + k;
            wlast  <= (k == beats - 1);
            cycles = 0;
            @(negedge clock);
            while (!wready && cycles < TIMEOUT) begin
                @(negedge clock);
                cycles++;
            end
            if (!wready) begin
                report_timeout("wready");
                return;
            end
            @(posedge clock);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        w_done = 1'b1;
        // write burst ends with the b handshake
        cycles = 0;
        @(negedge clock);
        while (!(bvalid && bready) && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!(bvalid && bready)) begin
            report_timeout("write response");
            return;
        end
        @(posedge clock);
    endtask

    task automatic run_read(input ddr_bridge_pkg::addr_t addr, input int beats);
        int k;
        int cycles;
        ddr_bridge_pkg::addr_t a;
        for (k = 0; k < beats; k++) begin
            a = ddr_bridge_pkg::addr_t'(addr + ddr_bridge_pkg::APP_ADDR_STEP * k);
            exp_cmd_addr.push_back(a);
            exp_cmd_code.push_back(ddr_bridge_pkg::APP_READ);
            exp_rd_data.push_back(expected_word(a));
            exp_rd_last.push_back(k == beats - 1);
        end
        @(posedge clock);
        arvalid <= 1'b1;
        araddr  <= addr;
        arlen   <= ddr_bridge_pkg::axi_len_t'(beats - 1);
        cycles = 0;
        @(negedge clock);
        while (!arready && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!arready) begin
            report_timeout("arready");
            return;
        end
        @(posedge clock);
        arvalid <= 1'b0;
        // read burst ends with the rlast handshake
        cycles = 0;
        @(negedge clock);
        while (!(rvalid && rready && rlast) && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!(rvalid && rready && rlast)) begin
            report_timeout("last read beat");
            return;
        end
        @(posedge clock);
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [7:0] dir_c;
        logic [31:0] addr_in;
        int beats_in;
        logic [63:0] base_in;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        awlen   = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wlast   = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arlen   = '0;
        foreach (exp_valid[i]) begin
            exp_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        fd = $fopen("tests/ddr_bridge_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            other_errors++;
            hung = 1'b1;
        end
        while (!hung && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %d %h", dir_c, addr_in, beats_in, base_in);
            if (n != 4) begin
                continue;
            end
            if (beats_in < 1 || beats_in > ddr_bridge_pkg::MAX_BEATS) begin
                $display("beat count %0d out of range in stimulus file", beats_in);
                other_errors++;
                continue;
            end
            if (dir_c == "W") begin
                n_writes++;
                run_write(ddr_bridge_pkg::addr_t'(addr_in), beats_in, base_in);
            end else begin
                run_read(ddr_bridge_pkg::addr_t'(addr_in), beats_in);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (!hung) begin
            if (exp_cmd_addr.size() != 0 || exp_rd_data.size() != 0) begin
                $display("commands or read beats left over at the end");
                other_errors++;
            end
            check_value("b handshake count", b_count, n_writes);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- write_path/axi_write_path.sv
// one write burst at a time; wlast must sit on beat awlen+1, bresp is always OKAY and not driven
module axi_write_path (
    input  logic                     clock,
    input  logic                     rst,
    input  logic                     awvalid,
    output logic                     awready,
    input  ddr_bridge_pkg::addr_t    awaddr,
    input  ddr_bridge_pkg::axi_len_t awlen,
    input  logic                     wvalid,
    output logic                     wready,
    input  ddr_bridge_pkg::data_t    wdata,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    output ddr_bridge_pkg::data_t    app_wdf_data,
    output logic                     app_wdf_wren,
    input  logic                     app_wdf_rdy,
    burst_req_if.path                seq
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_RESP
    } state_e;

    state_e                 state;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   wdf_hs;
    logic                   fifo_full;
    logic                   fifo_empty;
    // grant is latched so data may trail the commands
    logic                   granted;
    logic                   cmd_seen;
    logic                   data_seen;
    logic                   cmd_now;
    logic                   data_now;
    ddr_bridge_pkg::beats_t sent_cnt;

    assign aw_hs  = awvalid && awready;
    assign w_hs   = wvalid && wready;
    assign wdf_hs = app_wdf_wren && app_wdf_rdy;

    // events of this cycle merged with the sticky flags
    assign cmd_now  = cmd_seen || seq.cmd_done;
    assign data_now = data_seen || (wdf_hs && (sent_cnt == seq.beats - 1'b1));

    // send buffered beats once the sequencer owns this burst
    assign app_wdf_wren = (state == ST_BURST) && (granted || seq.grant)
                          && !fifo_empty && !data_seen;

    // burst descriptor held for the sequencer
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            seq.addr  <= awaddr;
            seq.beats <= ddr_bridge_pkg::beats_t'(awlen) + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            seq.req   <= 1'b0;
            granted   <= 1'b0;
            cmd_seen  <= 1'b0;
            data_seen <= 1'b0;
            sent_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // goes high on the first cycle out of reset
                    awready <= !aw_hs;
                    if (aw_hs) begin
                        state     <= ST_BURST;
                        wready    <= 1'b1;
                        seq.req   <= 1'b1;
                        cmd_seen  <= 1'b0;
                        data_seen <= 1'b0;
                        sent_cnt  <= '0;
                    end
                end
                ST_BURST: begin
                    if (w_hs && wlast) begin
                        wready <= 1'b0;
                    end
                    if (seq.grant) begin
                        granted <= 1'b1;
                    end
                    if (seq.cmd_done) begin
                        seq.req  <= 1'b0;
                        cmd_seen <= 1'b1;
                    end
                    if (wdf_hs) begin
                        sent_cnt <= sent_cnt + 1'b1;
                    end
                    if (data_now) begin
                        data_seen <= 1'b1;
                    end
                    // response once commands and data are both through
                    if (cmd_now && data_now) begin
                        state   <= ST_RESP;
                        bvalid  <= 1'b1;
                        granted <= 1'b0;
                    end
                end
                default: begin
                    if (bready) begin
                        state   <= ST_IDLE;
                        bvalid  <= 1'b0;
                        awready <= 1'b1;
                    end
                end
            endcase
        end
    end

    sync_fifo #(
        .payload_t(ddr_bridge_pkg::data_t)
    ) wr_fifo_i (
        .clock(clock),
        .rst  (rst),
        .push (w_hs),
        .din  (wdata),
        .pop  (wdf_hs),
        .dout (app_wdf_data),
        .full (fifo_full),
        .empty(fifo_empty)
    );

    // a buffered burst never overruns the FIFO
    a_w_fits: assert property (@(posedge clock) disable iff (rst) w_hs |-> !fifo_full);

    // response held until the master takes it
    a_b_hold: assert property (@(posedge clock) disable iff (rst)
        bvalid && !bready |=> bvalid);

endmodule
